// File: files.f
common/mseq_pkg.sv
design/cmd_deser.sv
design/phy_ctrl_regs.sv
design/wbuf_delay_line.sv
sequencer/cmd_seq_mem.sv
sequencer/seq_control.sv
sequencer/cmd_issue.sv
design/mcontr_sequencer.sv
verif/tb_mcontr_sequencer.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the sequencer testbench with verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f files.f \
    --top-module tb_mcontr_sequencer -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_tb > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "STATUS: FAIL" "$LOG"; then
    echo "simulation reported failure"
    exit 1
fi
if [ $status -ne 0 ]; then
    echo "simulator exited with status $status"
    exit 1
fi
echo "simulation finished without failure"
exit 0

// File: verif/tb_mcontr_sequencer.sv
//////////////////////////////////////////////////////////////////////
// testbench for the command sequencer, bus trace model, assertions
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module tb_mcontr_sequencer;

    localparam int CLK_PERIOD = 100;
    localparam int NUM_WORDS  = 24;                 // words per sequence, done word last
    localparam int MAX_PAUSE  = 5;
    localparam int MAX_OCC    = MAX_PAUSE + 2;      // word, pause, added nop
    localparam int TAIL       = 20;                 // covers longest write strobe delay
    localparam int NUM_RUNS   = 4;
    localparam int TRACE_MAX  = 512;
    localparam int WATCHDOG_CYC = NUM_RUNS * (NUM_WORDS * (MAX_OCC + 1) + TAIL + 40) + 300;

    logic                              mclk;
    logic                              rst;
    mseq_pkg::cmd_mem_wr_t             cmd0_wr;
    mseq_pkg::cmd_mem_wr_t             cmd1_wr;
    logic [mseq_pkg::RUN_ADDR_W-1:0]   run_addr;
    logic [mseq_pkg::CHN_W-1:0]        run_chn;
    logic                              run_seq;
    logic [mseq_pkg::CTRL_AD_W-1:0]    cmd_ad;
    logic                              cmd_stb;
    logic                              run_done;
    logic                              run_busy;
    logic                              mcontr_reset;
    logic                              sd_rst_n;
    mseq_pkg::ddr_bus_t                ddr_bus;
    logic                              buf_rd;
    logic                              buf_wr;
    logic [mseq_pkg::BUF_ADDR_W-1:0]   buf_addr;
    logic [mseq_pkg::CHN_W-1:0]        buf_chn;

    // expected outputs, updated on the falling edge
    mseq_pkg::ddr_bus_t                exp_bus;
    logic                              exp_rd;
    logic                              exp_wr;
    logic [mseq_pkg::BUF_ADDR_W-1:0]   exp_addr;
    logic                              exp_done;
    logic                              exp_busy;
    logic                              exp_mreset;
    logic [mseq_pkg::CHN_W-1:0]        exp_chn;
    logic                              chk_en;          // off while a control command settles

    // control state as the register map defines it
    logic                              cke_st;
    logic                              cmda_st;
    logic                              mreset_st;
    logic [mseq_pkg::WBUF_DLY_W-1:0]   dly_st;

    mseq_pkg::cmd_word_t               seq_words [NUM_WORDS];
    mseq_pkg::ddr_bus_t                tr_bus [TRACE_MAX];
    logic                              tr_rd [TRACE_MAX];
    logic                              tr_wr [TRACE_MAX];
    logic                              tr_done [TRACE_MAX];
    logic                              tr_busy [TRACE_MAX];
    logic [mseq_pkg::BUF_ADDR_W-1:0]   tr_addr [TRACE_MAX+1];
    integer                            seed;
    logic [15:0]                       rnd16;

    mcontr_sequencer dut_i (
        .mclk         (mclk),
        .rst          (rst),
        .cmd0_wr      (cmd0_wr),
        .cmd1_wr      (cmd1_wr),
        .run_addr     (run_addr),
        .run_chn      (run_chn),
        .run_seq      (run_seq),
        .cmd_ad       (cmd_ad),
        .cmd_stb      (cmd_stb),
        .run_done     (run_done),
        .run_busy     (run_busy),
        .mcontr_reset (mcontr_reset),
        .sd_rst_n     (sd_rst_n),
        .ddr_bus      (ddr_bus),
        .buf_rd       (buf_rd),
        .buf_wr       (buf_wr),
        .buf_addr     (buf_addr),
        .buf_chn      (buf_chn)
    );

    initial begin
        mclk = 1'b0;
        forever #(CLK_PERIOD / 2) mclk = ~mclk;
    end

    task automatic fail_check(input string msg);
        $display("ERROR: %0t ns: %s", $time, msg);
        $display("STATUS: FAIL");
        $fatal(1, "output check failed");
    endtask

    a_bus: assert property (@(posedge mclk) chk_en |-> ddr_bus == exp_bus)
        else fail_check($sformatf("ddr_bus %h, expected %h", $sampled(ddr_bus),
                                  $sampled(exp_bus)));
    a_rd: assert property (@(posedge mclk) chk_en |-> buf_rd == exp_rd)
        else fail_check($sformatf("buf_rd %b, expected %b", $sampled(buf_rd), $sampled(exp_rd)));
    a_wr: assert property (@(posedge mclk) chk_en |-> buf_wr == exp_wr)
        else fail_check($sformatf("buf_wr %b, expected %b", $sampled(buf_wr), $sampled(exp_wr)));
    a_addr: assert property (@(posedge mclk) chk_en |-> buf_addr == exp_addr)
        else fail_check($sformatf("buf_addr %0d, expected %0d", $sampled(buf_addr),
                                  $sampled(exp_addr)));
    a_done: assert property (@(posedge mclk) chk_en |-> run_done == exp_done)
        else fail_check($sformatf("run_done %b, expected %b", $sampled(run_done),
                                  $sampled(exp_done)));
    a_busy: assert property (@(posedge mclk) chk_en |-> run_busy == exp_busy)
        else fail_check($sformatf("run_busy %b, expected %b", $sampled(run_busy),
                                  $sampled(exp_busy)));
    a_mreset: assert property (@(posedge mclk)
        chk_en |-> (mcontr_reset == exp_mreset) && (sd_rst_n == !exp_mreset))
        else fail_check($sformatf("mcontr_reset %b sd_rst_n %b, expected reset %b",
                                  $sampled(mcontr_reset), $sampled(sd_rst_n),
                                  $sampled(exp_mreset)));
    a_chn: assert property (@(posedge mclk) chk_en |-> buf_chn == exp_chn)
        else fail_check($sformatf("buf_chn %0d, expected %0d", $sampled(buf_chn),
                                  $sampled(exp_chn)));

    function automatic mseq_pkg::ddr_bus_t idle_bus();
        mseq_pkg::ddr_bus_t b;
        b.cmd  = mseq_pkg::NOP;
        b.addr = '0;
        b.ba   = '0;
        b.odt  = 1'b0;
        b.cke  = cke_st;
        return b;
    endfunction

    task automatic set_idle();                      // buf_addr keeps its value
        exp_bus    = idle_bus();
        exp_rd     = 1'b0;
        exp_wr     = 1'b0;
        exp_done   = 1'b0;
        exp_busy   = 1'b0;
        exp_mreset = mreset_st;
    endtask

    task automatic send_ctrl(input logic [15:0] a, input int ndata, input logic [15:0] d);
        chk_en = 1'b0;
        @(negedge mclk);
        cmd_stb = 1'b1;
        cmd_ad  = a[7:0];
        @(negedge mclk);
        cmd_stb = 1'b0;
        cmd_ad  = a[15:8];
        if (ndata > 0) begin
            @(negedge mclk);
            cmd_ad = d[7:0];                        // data low byte first
            @(negedge mclk);
            cmd_ad = d[15:8];
        end
        @(negedge mclk);
        cmd_ad = '0;
        repeat (4) @(negedge mclk);                 // let the register settle
    endtask

    task automatic resume_checks();
        set_idle();
        chk_en = 1'b1;
    endtask

    task automatic gen_sequence();
        mseq_pkg::cmd_word_t w;
        logic [9:0]          pause;
        for (int i = 0; i < NUM_WORDS; i++) begin
            w     = mseq_pkg::cmd_word_t'($random(seed));
            pause = 10'($unsigned($random(seed)) % (MAX_PAUSE + 1));
            if ((($random(seed) & 3) == 0) || (i == NUM_WORDS - 1)) begin
                w.cmd = mseq_pkg::NOP;
            end
            if (w.cmd == mseq_pkg::NOP) begin
                w.addr[9:0]                = pause;
                w.addr[mseq_pkg::DONE_BIT] = (i == NUM_WORDS - 1); // only the last ends it
            end
            seq_words[i] = w;
        end
    endtask

    task automatic write_words(input logic bank, input logic [9:0] base);
        mseq_pkg::cmd_mem_wr_t wr;
        for (int i = 0; i < NUM_WORDS; i++) begin
            @(negedge mclk);
            wr.we   = 1'b1;
            wr.addr = base + 10'(i);
            wr.data = seq_words[i];
            if (bank) cmd1_wr = wr;
            else cmd0_wr = wr;
        end
        @(negedge mclk);
        cmd0_wr.we = 1'b0;
        cmd1_wr.we = 1'b0;
    endtask

    // occupancy rule, cycle k counts from the accepting edge
    task automatic build_trace(input logic en, output int len);
        mseq_pkg::cmd_word_t w;
        mseq_pkg::ddr_bus_t  b;
        int                  t;
        int                  done_t;
        for (int k = 0; k < TRACE_MAX; k++) begin
            tr_bus[k]  = idle_bus();
            tr_rd[k]   = 1'b0;
            tr_wr[k]   = 1'b0;
            tr_done[k] = 1'b0;
            tr_busy[k] = 1'b0;
        end
        t      = 3;                                 // first command on the bus
        done_t = 0;
        for (int i = 0; i < NUM_WORDS; i++) begin
            w = seq_words[i];
            if (en) begin
                b.cmd     = w.cmd;
                b.addr    = w.addr;
                b.ba      = w.ba;
                b.odt     = w.odt;
                b.cke     = cke_st;
                tr_bus[t] = b;
            end
            tr_rd[t] = w.buf_rd;
            if (w.buf_wr) tr_wr[t + int'(dly_st) + 1] = 1'b1;
            if (i == NUM_WORDS - 1) begin
                tr_done[t] = 1'b1;
                done_t     = t;
            end else begin
                t = t + 1 + int'(w.add_pause) +
                    ((w.cmd == mseq_pkg::NOP) ? int'(w.addr[9:0]) : 0);
            end
        end
        for (int k = 0; k <= done_t; k++) tr_busy[k] = 1'b1;
        len        = done_t + TAIL;
        tr_addr[0] = '0;                            // cleared on accept
        for (int k = 1; k <= len; k++) begin
            tr_addr[k] = tr_addr[k-1] + 7'(tr_rd[k-1] | tr_wr[k-1]);
        end
    endtask

    task automatic run_sequence(input logic bank, input logic en);
        logic [9:0] base;
        logic [3:0] chn;
        int         len;
        base = 10'($random(seed)) & 10'h3e0;        // room for the whole sequence
        chn  = 4'($random(seed));
        gen_sequence();
        write_words(bank, base);
        build_trace(en, len);
        @(negedge mclk);
        run_seq  = 1'b1;
        run_addr = {bank, base};
        run_chn  = chn;
        for (int k = 0; k < len; k++) begin
            @(negedge mclk);
            run_seq  = 1'b0;
            exp_bus  = tr_bus[k];
            exp_rd   = tr_rd[k];
            exp_wr   = tr_wr[k];
            exp_done = tr_done[k];
            exp_busy = tr_busy[k];
            exp_addr = tr_addr[k];
            exp_chn  = chn;
        end
        @(negedge mclk);
        set_idle();
        exp_addr = tr_addr[len];
    endtask

    initial begin
        #(WATCHDOG_CYC * CLK_PERIOD);
        $display("watchdog timeout: the tests did not finish in the expected time");
        $display("STATUS: FAIL");
        $fatal(1, "watchdog timeout");
    end

    initial begin
        seed      = 71207;
        rst       = 1'b1;
        cmd0_wr   = '0;
        cmd1_wr   = '0;
        run_addr  = '0;
        run_chn   = '0;
        run_seq   = 1'b0;
        cmd_ad    = '0;
        cmd_stb   = 1'b0;
        cke_st    = 1'b0;
        cmda_st   = 1'b0;
        mreset_st = 1'b1;
        dly_st    = mseq_pkg::DFLT_WBUF_DELAY;
        exp_addr  = '0;
        exp_chn   = '0;
        chk_en    = 1'b0;
        set_idle();
        repeat (5) @(negedge mclk);
        rst    = 1'b0;
        chk_en = 1'b1;                              // reset state from here on
        repeat (4) @(negedge mclk);
        run_seq = 1'b1;                             // ignored, memory reset active
        @(negedge mclk);
        run_seq = 1'b0;
        repeat (8) @(negedge mclk);
        send_ctrl(16'h0129, 0, 16'h0000);           // address miss, nothing changes
        resume_checks();
        send_ctrl(16'h0029, 0, 16'h0000);           // cke on
        cke_st = 1'b1;
        resume_checks();
        send_ctrl(16'h0026, 0, 16'h0000);           // memory reset released
        mreset_st = 1'b0;
        resume_checks();
        send_ctrl(16'h0025, 0, 16'h0000);           // command outputs on
        cmda_st = 1'b1;
        resume_checks();
        run_sequence(1'b0, cmda_st);
        run_sequence(1'b1, cmda_st);
        rnd16 = 16'($random(seed));
        if (rnd16[mseq_pkg::WBUF_DLY_W-1:0] == dly_st) begin
            rnd16[0] = ~rnd16[0];                   // new delay differs from the old one
        end
        send_ctrl(16'h0050 + 16'(mseq_pkg::REG16_WBUF_DELAY), 2, rnd16);
        dly_st = rnd16[mseq_pkg::WBUF_DLY_W-1:0];
        resume_checks();
        run_sequence(1'b1, cmda_st);
        send_ctrl(16'h0024, 0, 16'h0000);           // command outputs off
        cmda_st = 1'b0;
        resume_checks();
        run_sequence(1'b0, cmda_st);
        repeat (4) @(negedge mclk);
        $display("STATUS: PASS");
        $finish;
    end

endmodule

`default_nettype wire

// File: design/mcontr_sequencer.sv
//////////////////////////////////////////////////////////////////////
// ddr3 command sequencer top, control registers, memories, issue
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mcontr_sequencer (
    input  wire logic                            mclk,
    input  wire logic                            rst,
    input  wire mseq_pkg::cmd_mem_wr_t           cmd0_wr,      // manual bank
    input  wire mseq_pkg::cmd_mem_wr_t           cmd1_wr,      // auto bank
    input  wire logic [mseq_pkg::RUN_ADDR_W-1:0] run_addr,
    input  wire logic [mseq_pkg::CHN_W-1:0]      run_chn,
    input  wire logic                            run_seq,
    input  wire logic [mseq_pkg::CTRL_AD_W-1:0]  cmd_ad,
    input  wire logic                            cmd_stb,
    output logic                                 run_done,
    output logic                                 run_busy,
    output logic                                 mcontr_reset,
    output logic                                 sd_rst_n,
    output mseq_pkg::ddr_bus_t                   ddr_bus,
    output logic                                 buf_rd,
    output logic                                 buf_wr,
    output logic      [mseq_pkg::BUF_ADDR_W-1:0] buf_addr,
    output logic      [mseq_pkg::CHN_W-1:0]      buf_chn
);

    logic                          cmda_en;
    logic                          cke;
    logic [mseq_pkg::WBUF_DLY_W-1:0] wbuf_delay;
    mseq_pkg::cmd_word_t           word0;
    mseq_pkg::cmd_word_t           word1;
    mseq_pkg::cmd_word_t           word;
    logic                          ren0;
    logic                          ren1;
    logic [mseq_pkg::SEQ_ADDR_W-1:0] raddr;
    logic                          word_valid;
    logic                          seq_start;
    logic                          buf_wr_raw;

    assign sd_rst_n = ~mcontr_reset;               // memory pin is active low

    phy_ctrl_regs phy_ctrl_regs_i (
        .mclk       (mclk),
        .rst        (rst),
        .cmd_ad     (cmd_ad),
        .cmd_stb    (cmd_stb),
        .cmda_en    (cmda_en),
        .ddr_reset  (mcontr_reset),
        .cke        (cke),
        .wbuf_delay (wbuf_delay)
    );

    cmd_seq_mem cmd0_mem_i (.mclk(mclk), .wr(cmd0_wr), .raddr(raddr), .ren(ren0),
                            .rdata(word0));
    cmd_seq_mem cmd1_mem_i (.mclk(mclk), .wr(cmd1_wr), .raddr(raddr), .ren(ren1),
                            .rdata(word1));

    seq_control seq_control_i (
        .mclk       (mclk),
        .rst        (rst),
        .run_addr   (run_addr),
        .run_chn    (run_chn),
        .run_seq    (run_seq),
        .ddr_reset  (mcontr_reset),
        .word0      (word0),
        .word1      (word1),
        .word       (word),
        .ren0       (ren0),
        .ren1       (ren1),
        .raddr      (raddr),
        .word_valid (word_valid),
        .seq_start  (seq_start),
        .run_busy   (run_busy),
        .run_done   (run_done),
        .buf_chn    (buf_chn)
    );

    cmd_issue cmd_issue_i (
        .mclk       (mclk),
        .rst        (rst),
        .word       (word),
        .word_valid (word_valid),
        .cmda_en    (cmda_en),
        .cke        (cke),
        .seq_start  (seq_start),
        .buf_wr_dly (buf_wr),
        .ddr_bus    (ddr_bus),
        .buf_rd     (buf_rd),
        .buf_wr_raw (buf_wr_raw),
        .buf_addr   (buf_addr)
    );

    wbuf_delay_line wbuf_delay_line_i (
        .mclk (mclk),
        .rst  (rst),
        .dly  (wbuf_delay),
        .din  (buf_wr_raw),
        .dout (buf_wr)
    );

endmodule

`default_nettype wire

// File: sequencer/cmd_issue.sv
//////////////////////////////////////////////////////////////////////
// ddr3 command bus register, buffer strobes, buffer address counter
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmd_issue (
    input  wire logic                            mclk,
    input  wire logic                            rst,
    input  wire mseq_pkg::cmd_word_t             word,
    input  wire logic                            word_valid,
    input  wire logic                            cmda_en,
    input  wire logic                            cke,
    input  wire logic                            seq_start,
    input  wire logic                            buf_wr_dly,  // from delay line
    output mseq_pkg::ddr_bus_t                   ddr_bus,
    output logic                                 buf_rd,
    output logic                                 buf_wr_raw,
    output logic      [mseq_pkg::BUF_ADDR_W-1:0] buf_addr
);

    logic issue;

    assign issue = word_valid && cmda_en;          // disabled outputs show nop

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            ddr_bus.cmd  <= mseq_pkg::NOP;
            ddr_bus.addr <= '0;
            ddr_bus.ba   <= '0;
            ddr_bus.odt  <= 1'b0;
            ddr_bus.cke  <= 1'b0;
            buf_rd       <= 1'b0;
            buf_wr_raw   <= 1'b0;
        end else begin
            ddr_bus.cmd  <= issue ? word.cmd : mseq_pkg::NOP;
            ddr_bus.addr <= issue ? word.addr : '0;
            ddr_bus.ba   <= issue ? word.ba : '0;
            ddr_bus.odt  <= issue && word.odt;
            ddr_bus.cke  <= cke;
            buf_rd       <= word_valid && word.buf_rd;   // aligned with bus
            buf_wr_raw   <= word_valid && word.buf_wr;
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            buf_addr <= '0;
        end else if (seq_start) begin
            buf_addr <= '0;
        end else if (buf_rd || buf_wr_dly) begin
            buf_addr <= buf_addr + 1'b1;            // one per strobe cycle
        end
    end

endmodule

`default_nettype wire

// File: sequencer/seq_control.sv
//////////////////////////////////////////////////////////////////////
// sequence run control, fetch and pause stall, read address, done
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module seq_control (
    input  wire logic                            mclk,
    input  wire logic                            rst,
    input  wire logic [mseq_pkg::RUN_ADDR_W-1:0] run_addr,
    input  wire logic [mseq_pkg::CHN_W-1:0]      run_chn,
    input  wire logic                            run_seq,
    input  wire logic                            ddr_reset,
    input  wire mseq_pkg::cmd_word_t             word0,      // bank 0 memory output
    input  wire mseq_pkg::cmd_word_t             word1,      // bank 1 memory output
    output mseq_pkg::cmd_word_t                  word,       // selected bank word
    output logic                                 ren0,
    output logic                                 ren1,
    output logic      [mseq_pkg::SEQ_ADDR_W-1:0] raddr,
    output logic                                 word_valid,
    output logic                                 seq_start,
    output logic                                 run_busy,
    output logic                                 run_done,
    output logic      [mseq_pkg::CHN_W-1:0]      buf_chn
);

    logic [1:0]                    busy;      // [1] enables fetch one cycle later
    logic                          bank;
    logic                          fetch;     // word on memory output is fresh
    logic [mseq_pkg::PAUSE_W:0]    pause_cnt; // remaining hold cycles
    logic [mseq_pkg::PAUSE_W:0]    hold_len;
    logic [mseq_pkg::PAUSE_W-1:0]  pause_len;
    logic                          is_nop;
    logic                          is_done;
    logic                          stall;
    logic                          ren;

    assign word       = bank ? word1 : word0;
    assign is_nop     = (word.cmd == mseq_pkg::NOP);
    assign pause_len  = word.addr[mseq_pkg::PAUSE_W-1:0];
    assign is_done    = is_nop && word.addr[mseq_pkg::DONE_BIT];
    assign hold_len   = (mseq_pkg::PAUSE_W+1)'(is_nop ? pause_len : '0) +
                        (mseq_pkg::PAUSE_W+1)'(word.add_pause);
    assign word_valid = fetch;
    assign seq_start  = run_seq && !busy[0] && !ddr_reset;   // accept
    assign run_busy   = busy[0];

    // fresh word decides the stall itself, later cycles use the counter
    assign stall = fetch ? (is_done || (hold_len != '0))
                         : (|pause_cnt[mseq_pkg::PAUSE_W:1]);
    assign ren   = busy[1] && !stall && !run_done;
    assign ren0  = ren && !bank;
    assign ren1  = ren && bank;

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            busy <= '0;
        end else if (ddr_reset || run_done) begin
            busy <= '0;                             // abort or sequence end
        end else begin
            busy <= {busy[0], busy[0] | seq_start};
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            fetch     <= 1'b0;
            run_done  <= 1'b0;
            pause_cnt <= '0;
        end else begin
            fetch    <= ren && !ddr_reset;
            run_done <= fetch && is_done && !ddr_reset; // with done word on bus
            if (!busy[1]) begin
                pause_cnt <= '0;
            end else if (fetch) begin
                pause_cnt <= is_done ? '0 : hold_len; // done pause ignored
            end else if (pause_cnt != '0) begin
                pause_cnt <= pause_cnt - 1'b1;
            end
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            raddr   <= '0;
            bank    <= 1'b0;
            buf_chn <= '0;
        end else if (seq_start) begin
            raddr   <= run_addr[mseq_pkg::SEQ_ADDR_W-1:0];
            bank    <= run_addr[mseq_pkg::RUN_ADDR_W-1];
            buf_chn <= run_chn;
        end else if (ren) begin
            raddr   <= raddr + 1'b1;
        end
    end

    // back-to-back reads never switch banks
    a_one_bank: assert property (@(posedge mclk) disable iff (rst)
        (ren0 || ren1) && $past(ren0 || ren1) |-> (ren1 == $past(ren1)));

    a_done_busy: assert property (@(posedge mclk) disable iff (rst)
        run_done |-> run_busy);

endmodule

`default_nettype wire

// File: sequencer/cmd_seq_mem.sv
//////////////////////////////////////////////////////////////////////
// 1k x 32 command sequence memory, registered read with hold
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmd_seq_mem (
    input  wire logic                            mclk,
    input  wire mseq_pkg::cmd_mem_wr_t           wr,
    input  wire logic [mseq_pkg::SEQ_ADDR_W-1:0] raddr,
    input  wire logic                            ren,
    output mseq_pkg::cmd_word_t                  rdata
);

    mseq_pkg::cmd_word_t mem [2**mseq_pkg::SEQ_ADDR_W];

    always_ff @(posedge mclk) begin
        if (wr.we) begin
            mem[wr.addr] <= mseq_pkg::cmd_word_t'(wr.data);
        end
    end

    always_ff @(posedge mclk) begin
        if (ren) begin
            rdata <= mem[raddr];                    // holds while ren low
        end
    end

endmodule

`default_nettype wire

// File: design/wbuf_delay_line.sv
//////////////////////////////////////////////////////////////////////
// programmable 1 to 16 cycle delay for the buffer write strobe
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module wbuf_delay_line (
    input  wire logic                            mclk,
    input  wire logic                            rst,
    input  wire logic [mseq_pkg::WBUF_DLY_W-1:0] dly,
    input  wire logic                            din,
    output logic                                 dout
);

    logic [2**mseq_pkg::WBUF_DLY_W-1:0] taps;      // taps[0] is din one cycle late

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            taps <= '0;
        end else begin
            taps <= {taps[2**mseq_pkg::WBUF_DLY_W-2:0], din};
        end
    end

    assign dout = taps[dly];                        // dly+1 cycles

endmodule

`default_nettype wire

// File: design/phy_ctrl_regs.sv
//////////////////////////////////////////////////////////////////////
// control registers from 0-bit and 16-bit channel commands
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module phy_ctrl_regs (
    input  wire logic                            mclk,
    input  wire logic                            rst,
    input  wire logic [mseq_pkg::CTRL_AD_W-1:0]  cmd_ad,
    input  wire logic                            cmd_stb,
    output logic                                 cmda_en,    // command outputs enabled
    output logic                                 ddr_reset,  // memory reset, active high
    output logic                                 cke,
    output logic      [mseq_pkg::WBUF_DLY_W-1:0] wbuf_delay
);

    logic [3:0]  addr0;
    logic        we0;
    logic [3:0]  addr16;
    logic [15:0] data16;
    logic        we16;

    cmd_deser #(
        .ADDR      (mseq_pkg::PHY_0BIT_ADDR),
        .ADDR_MASK (mseq_pkg::PHY_0BIT_MASK),
        .NUM_BYTES (2),
        .DATA_W    (0)
    ) deser_0bit_i (
        .mclk (mclk),
        .rst  (rst),
        .ad   (cmd_ad),
        .stb  (cmd_stb),
        .addr (addr0),
        .data (),                                   // no payload
        .we   (we0)
    );

    cmd_deser #(
        .ADDR      (mseq_pkg::PHY_16BIT_ADDR),
        .ADDR_MASK (mseq_pkg::PHY_16BIT_MASK),
        .NUM_BYTES (4),
        .DATA_W    (16)
    ) deser_16bit_i (
        .mclk (mclk),
        .rst  (rst),
        .ad   (cmd_ad),
        .stb  (cmd_stb),
        .addr (addr16),
        .data (data16),
        .we   (we16)
    );

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            cmda_en   <= 1'b0;
            ddr_reset <= 1'b1;                      // memory held in reset
            cke       <= 1'b0;
        end else if (we0) begin
            case (mseq_pkg::phy_op_e'(addr0[3:1]))
                mseq_pkg::OP_CMDA_EN:   cmda_en   <= addr0[0];
                mseq_pkg::OP_SDRST_ACT: ddr_reset <= addr0[0];
                mseq_pkg::OP_CKE_EN:    cke       <= addr0[0];
                default: ;                          // other codes not kept
            endcase
        end
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            wbuf_delay <= mseq_pkg::DFLT_WBUF_DELAY;
        end else if (we16 && (addr16 == mseq_pkg::REG16_WBUF_DELAY)) begin
            wbuf_delay <= data16[mseq_pkg::WBUF_DLY_W-1:0]; // low bits only
        end
    end

endmodule

`default_nettype wire

// File: design/cmd_deser.sv
//////////////////////////////////////////////////////////////////////
// byte-serial command deserializer with masked address match
//////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module cmd_deser #(
    parameter logic [15:0] ADDR      = 16'h0000,
    parameter logic [15:0] ADDR_MASK = 16'hffff,
    parameter int          NUM_BYTES = 2,       // address low/high plus data bytes
    parameter int          DATA_W    = 0
) (
    input  wire logic                           mclk,
    input  wire logic                           rst,
    input  wire logic [mseq_pkg::CTRL_AD_W-1:0] ad,
    input  wire logic                           stb,   // with address low byte
    output logic      [3:0]                     addr,
    output logic      [15:0]                    data,
    output logic                                we
);

    localparam int SR_W = NUM_BYTES * mseq_pkg::CTRL_AD_W;
    localparam logic [15:0] DATA_MASK = 16'((32'd1 << DATA_W) - 1);

    logic [SR_W-1:0]      sr;      // last NUM_BYTES bytes, oldest at bottom
    logic [31:0]          sr_ext;
    logic [NUM_BYTES-1:0] phase;   // stb travelling with the bytes

    always_ff @(posedge mclk) begin
        sr <= {ad, sr[SR_W-1:mseq_pkg::CTRL_AD_W]};
    end

    always_ff @(posedge mclk or posedge rst) begin
        if (rst) begin
            phase <= '0;
        end else begin
            phase <= {phase[NUM_BYTES-2:0], stb};
        end
    end

    assign sr_ext = 32'(sr);                          // no data bytes -> zeros above
    assign addr   = sr_ext[3:0];
    assign data   = sr_ext[31:16] & DATA_MASK;
    assign we     = phase[NUM_BYTES-1] &&
                    ((sr_ext[15:0] & ADDR_MASK) == (ADDR & ADDR_MASK));

    // commands do not overlap on the channel
    a_no_overlap: assert property (@(posedge mclk) disable iff (rst)
        stb |-> (phase[NUM_BYTES-2:0] == '0));

endmodule

`default_nettype wire

// File: common/mseq_pkg.sv
//////////////////////////////////////////////////////////////////////
// sequencer widths, command word and bus structs, command enums,
// control register map
//////////////////////////////////////////////////////////////////////
`default_nettype none

package mseq_pkg;

    localparam int SEQ_ADDR_W = 10;     // word address in one bank
    localparam int RUN_ADDR_W = 11;     // msb selects the bank
    localparam int CMD_WORD_W = 32;
    localparam int DDR_ADDR_W = 15;
    localparam int DDR_BA_W   = 3;
    localparam int PAUSE_W    = 10;     // nop pause length in addr[9:0]
    localparam int DONE_BIT   = 10;     // nop addr bit ending a sequence
    localparam int BUF_ADDR_W = 7;
    localparam int CHN_W      = 4;
    localparam int WBUF_DLY_W = 4;
    localparam int CTRL_AD_W  = 8;      // control channel byte

    // {ras, cas, we}, all active low
    typedef enum logic [2:0] {
        NOP       = 3'b111,
        ACTIVATE  = 3'b011,
        READ      = 3'b101,
        WRITE     = 3'b100,
        PRECHARGE = 3'b010,
        REFRESH   = 3'b001,
        MODE_SET  = 3'b000,
        ZQ_CAL    = 3'b110
    } ddr_cmd_e;

    // 0-bit register codes, address bits [3:1]; bit 0 carries the value
    typedef enum logic [2:0] {
        OP_CMDA_EN   = 3'd2,            // addresses 4/5
        OP_SDRST_ACT = 3'd3,            // addresses 6/7
        OP_CKE_EN    = 3'd4             // addresses 8/9
    } phy_op_e;

    typedef struct packed {
        logic [DDR_ADDR_W-1:0] addr;    // pause length and done flag in a nop
        logic [DDR_BA_W-1:0]   ba;
        ddr_cmd_e              cmd;
        logic                  odt;
        logic                  buf_rd;  // read strobe toward channel buffer
        logic                  buf_wr;  // write strobe, goes through delay line
        logic                  add_pause; // one extra nop cycle after this word
        logic [6:0]            rsvd;
    } cmd_word_t;

    typedef struct packed {
        ddr_cmd_e              cmd;
        logic [DDR_ADDR_W-1:0] addr;
        logic [DDR_BA_W-1:0]   ba;
        logic                  odt;
        logic                  cke;
    } ddr_bus_t;

    typedef struct packed {
        logic                  we;
        logic [SEQ_ADDR_W-1:0] addr;
        logic [CMD_WORD_W-1:0] data;
    } cmd_mem_wr_t;

    localparam logic [15:0] PHY_0BIT_ADDR   = 16'h020;
    localparam logic [15:0] PHY_0BIT_MASK   = 16'h3f0;
    localparam logic [15:0] PHY_16BIT_ADDR  = 16'h050;
    localparam logic [15:0] PHY_16BIT_MASK  = 16'h3f8;
    localparam logic [3:0]  REG16_WBUF_DELAY = 4'd2;

    localparam logic [WBUF_DLY_W-1:0] DFLT_WBUF_DELAY = 4'd6;

endpackage

`default_nettype wire
